//--- hw/epu_pkg.sv
`default_nettype none

package epu_pkg;

  // weight buffer geometry
  localparam int WADDR_W = 10;
  localparam int WDATA_W = 32;
  localparam int WDEPTH  = 1 << WADDR_W;

  // each weight word packs four signed 8-bit lanes
  localparam int LANES  = 4;
  localparam int LANE_W = 8;

  // engine arithmetic
  localparam int PROD_W = 2 * LANE_W;
  localparam int ACC_W  = 32;

  // run length, 1 to 256 words
  localparam int LEN_W   = 9;
  localparam int MAX_LEN = 256;

  // single-port SRAM request
  typedef struct packed {
    logic               cs;
    logic               we;
    logic [WADDR_W-1:0] addr;
    logic [WDATA_W-1:0] wdata;
  } sram_req_t;

  // who currently owns the weight buffer
  typedef enum logic [1:0] {
    OWN_IDLE       = 2'd0,
    OWN_HOST_LOAD  = 2'd1,
    OWN_EPU_ACCESS = 2'd2
  } own_state_e;

endpackage

`default_nettype wire

//--- hw/host_pkg.sv
`default_nettype none

package host_pkg;

  // host opcode field width
  localparam int HOST_OP_W = 2;

  // host side follows the weight buffer geometry
  localparam int HOST_ADDR_W = epu_pkg::WADDR_W;
  localparam int HOST_DATA_W = epu_pkg::WDATA_W;

  // load port opcodes
  typedef enum logic [HOST_OP_W-1:0] {
    HOST_NOP   = 2'd0,
    HOST_BEGIN = 2'd1,
    HOST_WRITE = 2'd2,
    HOST_END   = 2'd3
  } host_op_e;

  // one host command, qualified by a separate valid strobe
  typedef struct packed {
    host_op_e               op;
    logic [HOST_ADDR_W-1:0] addr;
    logic [HOST_DATA_W-1:0] wdata;
  } host_req_t;

endpackage

`default_nettype wire

//--- hw/weight_sram.sv
`timescale 1ns/1ps
`default_nettype none

module weight_sram (
  input  wire logic                         clk,
  input  wire epu_pkg::sram_req_t           req_i,
  output logic [epu_pkg::WDATA_W-1:0]       rdata_o
);

  // storage array
  logic [epu_pkg::WDATA_W-1:0] mem [epu_pkg::WDEPTH];

  // write port
  // takes the word at the edge ending the request cycle
  always_ff @(posedge clk) begin
    if (req_i.cs && req_i.we) begin
      mem[req_i.addr] <= req_i.wdata;
    end
  end

  // read port, one cycle of latency
  // output holds when there is no read
  always_ff @(posedge clk) begin
    if (req_i.cs && !req_i.we) begin
      rdata_o <= mem[req_i.addr];
    end
  end

endmodule

`default_nettype wire

//--- hw/weight_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module weight_wrapper (
  input  wire logic                         clk,
  input  wire logic                         rst,
  // host load port
  input  wire logic                         host_valid_i,
  input  wire host_pkg::host_req_t          host_req_i,
  // engine side
  input  wire epu_pkg::sram_req_t           epu_req_i,
  output logic [epu_pkg::WDATA_W-1:0]       epu_rdata_o,
  output logic                              epu_ready_o,
  output logic                              host_err_o
);

  epu_pkg::own_state_e         state_q;
  epu_pkg::own_state_e         state_d;
  logic                        host_wr;
  epu_pkg::sram_req_t          sram_req;
  logic [epu_pkg::WDATA_W-1:0] sram_rdata;

  weight_sram u_sram (
    .clk     (clk),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= epu_pkg::OWN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // host command decode and ownership transitions
  // illegal commands are dropped and flagged in the same cycle
  always_comb begin
    state_d    = state_q;
    host_wr    = 1'b0;
    host_err_o = 1'b0;
    if (host_valid_i) begin
      case (host_req_i.op)
        host_pkg::HOST_BEGIN: begin
          if (state_q == epu_pkg::OWN_HOST_LOAD) begin
            host_err_o = 1'b1;
          end else begin
            state_d = epu_pkg::OWN_HOST_LOAD;
          end
        end
        host_pkg::HOST_WRITE: begin
          if (state_q == epu_pkg::OWN_HOST_LOAD) begin
            host_wr = 1'b1;
          end else begin
            host_err_o = 1'b1;
          end
        end
        host_pkg::HOST_END: begin
          if (state_q == epu_pkg::OWN_HOST_LOAD) begin
            state_d = epu_pkg::OWN_EPU_ACCESS;
          end else begin
            host_err_o = 1'b1;
          end
        end
        default: begin
          // nop
        end
      endcase
    end
  end

  // SRAM steering
  // host only writes, engine only reads
  always_comb begin
    sram_req = '0;
    case (state_q)
      epu_pkg::OWN_HOST_LOAD: begin
        if (host_wr) begin
          sram_req.cs    = 1'b1;
          sram_req.we    = 1'b1;
          sram_req.addr  = host_req_i.addr;
          sram_req.wdata = host_req_i.wdata;
        end
      end
      epu_pkg::OWN_EPU_ACCESS: begin
        sram_req.cs   = epu_req_i.cs;
        sram_req.addr = epu_req_i.addr;
      end
      default: begin
        // idle, buffer untouched
      end
    endcase
  end

  // read data only reaches the engine while it owns the buffer
  assign epu_rdata_o = (state_q == epu_pkg::OWN_EPU_ACCESS) ? sram_rdata : '0;
  assign epu_ready_o = (state_q == epu_pkg::OWN_EPU_ACCESS);

  a_wr_only_in_load: assert property (@(posedge clk) disable iff (rst)
    (sram_req.cs && sram_req.we) |-> (state_q == epu_pkg::OWN_HOST_LOAD));

  // every SRAM write traces back to a host write strobe
  a_wr_from_host: assert property (@(posedge clk) disable iff (rst)
    (sram_req.cs && sram_req.we) |->
      (host_valid_i && host_req_i.op == host_pkg::HOST_WRITE));

endmodule

`default_nettype wire

//--- hw/dot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dot_engine (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // run request
  input  wire logic                          start_i,
  input  wire logic [epu_pkg::WADDR_W-1:0]   base_i,
  input  wire logic [epu_pkg::LEN_W-1:0]     len_i,
  input  wire logic [epu_pkg::WDATA_W-1:0]   act_i,
  // weight buffer read side
  output epu_pkg::sram_req_t                 rd_req_o,
  input  wire logic [epu_pkg::WDATA_W-1:0]   rdata_i,
  // status and result
  output logic                               busy_o,
  output logic                               done_o,
  output logic signed [epu_pkg::ACC_W-1:0]   result_o
);

  localparam int WADDR_W = epu_pkg::WADDR_W;
  localparam int LEN_W   = epu_pkg::LEN_W;
  localparam int ACC_W   = epu_pkg::ACC_W;
  localparam int PROD_W  = epu_pkg::PROD_W;
  localparam int LANE_W  = epu_pkg::LANE_W;

  logic                        start_ok;
  logic [LEN_W-1:0]            len_eff;
  logic                        last_issue;
  logic                        issuing_q;
  logic [WADDR_W-1:0]          addr_q;
  logic [LEN_W-1:0]            remain_q;
  logic [epu_pkg::WDATA_W-1:0] act_q;
  logic                        dv_q;
  logic                        last_q;
  logic                        done_q;
  logic signed [PROD_W-1:0]    prod [epu_pkg::LANES];
  logic signed [ACC_W-1:0]     contrib;
  logic signed [ACC_W-1:0]     acc_q;
  logic signed [ACC_W-1:0]     acc_d;
  logic signed [ACC_W-1:0]     result_q;

  assign start_ok   = start_i && !busy_o;
  // zero encodes the longest run
  assign len_eff    = (len_i == '0) ? LEN_W'(epu_pkg::MAX_LEN) : len_i;
  assign last_issue = issuing_q && (remain_q == LEN_W'(1));

  // issue side, one read per cycle
  // address wraps at the top of the buffer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      issuing_q <= 1'b0;
      addr_q    <= '0;
      remain_q  <= '0;
    end else if (start_ok) begin
      issuing_q <= 1'b1;
      addr_q    <= base_i;
      remain_q  <= len_eff;
    end else if (issuing_q) begin
      addr_q   <= addr_q + WADDR_W'(1);
      remain_q <= remain_q - LEN_W'(1);
      if (last_issue) begin
        issuing_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      act_q <= act_i;
    end
  end

  // valid and last tag trail the issue by the SRAM latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dv_q   <= 1'b0;
      last_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      dv_q   <= issuing_q;
      last_q <= last_issue;
      done_q <= last_q;
    end
  end

  // lane products, sign extended and summed
  always_comb begin
    contrib = '0;
    for (int i = 0; i < epu_pkg::LANES; i++) begin
      prod[i] = $signed(rdata_i[i*LANE_W +: LANE_W]) * $signed(act_q[i*LANE_W +: LANE_W]);
      contrib = contrib + {{(ACC_W-PROD_W){prod[i][PROD_W-1]}}, prod[i]};
    end
  end

  assign acc_d = acc_q + contrib;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q    <= '0;
      result_q <= '0;
    end else if (start_ok) begin
      acc_q <= '0;
    end else if (dv_q) begin
      acc_q <= acc_d;
      // last word closes the sum
      if (last_q) begin
        result_q <= acc_d;
      end
    end
  end

  assign rd_req_o.cs    = issuing_q;
  assign rd_req_o.we    = 1'b0;
  assign rd_req_o.addr  = addr_q;
  assign rd_req_o.wdata = '0;

  assign busy_o   = issuing_q | dv_q | done_q;
  assign done_o   = done_q;
  assign result_o = result_q;

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_o |=> !done_o);

  a_no_write: assert property (@(posedge clk) disable iff (rst)
    rd_req_o.cs |-> !rd_req_o.we);

endmodule

`default_nettype wire

//--- hw/epu_top.sv
`timescale 1ns/1ps
`default_nettype none

module epu_top (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // host load port
  input  wire logic                          host_valid_i,
  input  wire host_pkg::host_req_t           host_req_i,
  // engine run request
  input  wire logic                          start_i,
  input  wire logic [epu_pkg::WADDR_W-1:0]   base_i,
  input  wire logic [epu_pkg::LEN_W-1:0]     len_i,
  input  wire logic [epu_pkg::WDATA_W-1:0]   act_i,
  // status
  output logic                               epu_ready_o,
  output logic                               host_err_o,
  output logic                               busy_o,
  output logic                               done_o,
  output logic signed [epu_pkg::ACC_W-1:0]   result_o
);

  // engine read path through the wrapper
  epu_pkg::sram_req_t          epu_rd_req;
  logic [epu_pkg::WDATA_W-1:0] epu_rdata;

  // owns the SRAM and arbitrates host against engine
  weight_wrapper u_wrapper (
    .clk          (clk),
    .rst          (rst),
    .host_valid_i (host_valid_i),
    .host_req_i   (host_req_i),
    .epu_req_i    (epu_rd_req),
    .epu_rdata_o  (epu_rdata),
    .epu_ready_o  (epu_ready_o),
    .host_err_o   (host_err_o)
  );

  dot_engine u_engine (
    .clk      (clk),
    .rst      (rst),
    .start_i  (start_i),
    .base_i   (base_i),
    .len_i    (len_i),
    .act_i    (act_i),
    .rd_req_o (epu_rd_req),
    .rdata_i  (epu_rdata),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_epu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_epu_top;

  localparam int N_RANDOM_RUNS = 20;
  // test lengths in steps, each step is one host command or one run
  localparam int RESET_STEPS  = 4;
  localparam int LOAD_STEPS   = 2 * epu_pkg::WDEPTH + 4;
  localparam int RUN_STEPS    = N_RANDOM_RUNS + 2;
  localparam int ERR_STEPS    = 12;
  localparam int OWN_STEPS    = 6;
  localparam int RELOAD_STEPS = 16;
  localparam int WATCH_CYCLES =
    300 * (RESET_STEPS + LOAD_STEPS + RUN_STEPS + ERR_STEPS + OWN_STEPS + RELOAD_STEPS);

  logic                  clk;
  logic                  rst;
  logic                  host_valid_i;
  host_pkg::host_req_t   host_req_i;
  logic                  start_i;
  logic [9:0]            base_i;
  logic [8:0]            len_i;
  logic [31:0]           act_i;
  logic                  epu_ready_o;
  logic                  host_err_o;
  logic                  busy_o;
  logic                  done_o;
  logic signed [31:0]    result_o;

  // words written so far, the model reads from here
  logic [31:0] shadow [epu_pkg::WDEPTH];
  logic [31:0] rng_state;
  int          err_count;

  epu_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .host_valid_i (host_valid_i),
    .host_req_i   (host_req_i),
    .start_i      (start_i),
    .base_i       (base_i),
    .len_i        (len_i),
    .act_i        (act_i),
    .epu_ready_o  (epu_ready_o),
    .host_err_o   (host_err_o),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .result_o     (result_o)
  );

  always #50 clk = ~clk;

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // reference dot product over the shadow copy, wraps at the top address
  function automatic logic [31:0] dot_model(input logic [9:0] base, input int len,
                                             input logic [31:0] act);
    int         sum;
    logic [9:0] a;
    byte        wl;
    byte        al;
    sum = 0;
    a = base;
    for (int k = 0; k < len; k++) begin
      for (int i = 0; i < 4; i++) begin
        wl = shadow[a][8*i +: 8];
        al = act[8*i +: 8];
        sum = sum + int'(wl) * int'(al);
      end
      a = a + 10'd1;
    end
    return sum;
  endfunction

  task check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count = err_count + 1;
      $display("Error: %s got %h expected %h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one host strobe, error flag checked in the strobe cycle and the one after
  task host_cmd(input host_pkg::host_op_e op, input logic [9:0] addr,
                input logic [31:0] data, input logic exp_err);
    @(posedge clk);
    host_valid_i      <= 1'b1;
    host_req_i.op     <= op;
    host_req_i.addr   <= addr;
    host_req_i.wdata  <= data;
    @(negedge clk);
    check("host_err_o", 32'(host_err_o), 32'(exp_err));
    @(posedge clk);
    host_valid_i <= 1'b0;
    @(negedge clk);
    check("host_err_o", 32'(host_err_o), 32'h0);
    if (op == host_pkg::HOST_WRITE && !exp_err) begin
      shadow[addr] = data;
    end
  endtask

  // start a run, optionally retry a start in the last data cycle while busy
  task run_dot(input logic [9:0] base, input int len, input logic [31:0] act,
               input logic [31:0] exp, input logic extra, input int tail);
    int   cyc;
    logic seen;
    @(posedge clk);
    start_i <= 1'b1;
    base_i  <= base;
    len_i   <= (len == 256) ? 9'd0 : len[8:0];
    act_i   <= act;
    cyc = 0;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      cyc = cyc + 1;
      start_i <= extra && (cyc == len + 1);
      if (extra && cyc == len + 1) begin
        base_i <= base + 10'd7;
        len_i  <= 9'd3;
        act_i  <= ~act;
      end
      @(negedge clk);
      check("busy_o", 32'(busy_o), 32'h1);
      if (done_o) begin
        seen = 1'b1;
      end else if (cyc > len + 10) begin
        $display("done_o never arrived for the run at base %h", base);
        $display("Checks failed");
        $fatal(1, "missing done");
      end
    end
    check("done latency", cyc, len + 2);
    check("result_o", result_o, exp);
    repeat (tail) begin
      @(negedge clk);
      check("done_o", 32'(done_o), 32'h0);
      check("busy_o", 32'(busy_o), 32'h0);
    end
  endtask

  task test_reset();
    @(negedge clk);
    check("epu_ready_o", 32'(epu_ready_o), 32'h0);
    check("host_err_o", 32'(host_err_o), 32'h0);
    check("busy_o", 32'(busy_o), 32'h0);
    check("done_o", 32'(done_o), 32'h0);
    check("result_o", result_o, 32'h0);
  endtask

  task test_load_handover();
    logic [31:0] w;
    host_cmd(host_pkg::HOST_BEGIN, 10'd0, 32'h0, 1'b0);
    check("epu_ready_o", 32'(epu_ready_o), 32'h0);
    // fill the whole buffer so later runs never read unwritten words
    for (int a = 0; a < epu_pkg::WDEPTH; a++) begin
      host_cmd(host_pkg::HOST_WRITE, a[9:0], next_rand(), 1'b0);
    end
    host_cmd(host_pkg::HOST_END, 10'd0, 32'h0, 1'b0);
    check("epu_ready_o", 32'(epu_ready_o), 32'h1);
    // lane 0 activation only, result is the sign extended lane 0 weight
    for (int a = 0; a < epu_pkg::WDEPTH; a++) begin
      w = shadow[a];
      run_dot(a[9:0], 1, 32'h0000_0001, {{24{w[7]}}, w[7:0]}, 1'b0, 1);
    end
  endtask

  task test_random_runs();
    logic [31:0] r;
    logic [9:0]  base;
    int          len;
    logic [31:0] act;
    for (int n = 0; n < N_RANDOM_RUNS; n++) begin
      r = next_rand();
      base = r[9:0];
      len = int'(r[17:10]) + 1;
      act = next_rand();
      run_dot(base, len, act, dot_model(base, len, act), 1'b0, 1);
    end
    // wrap past the top address, then the longest run
    act = next_rand();
    run_dot(10'd1020, 16, act, dot_model(10'd1020, 16, act), 1'b0, 1);
    r = next_rand();
    base = r[9:0];
    run_dot(base, 256, act, dot_model(base, 256, act), 1'b0, 1);
  endtask

  task test_protocol_errors();
    logic [31:0] r;
    logic [9:0]  addr;
    logic [31:0] act;
    r = next_rand();
    addr = r[9:0];
    act = next_rand() | 32'h0000_0001;
    host_cmd(host_pkg::HOST_WRITE, addr, ~shadow[addr], 1'b1);
    // memory must still hold the old word
    run_dot(addr, 1, act, dot_model(addr, 1, act), 1'b0, 1);
    host_cmd(host_pkg::HOST_END, 10'd0, 32'h0, 1'b1);
    host_cmd(host_pkg::HOST_NOP, 10'd0, 32'h0, 1'b0);
    host_cmd(host_pkg::HOST_BEGIN, 10'd0, 32'h0, 1'b0);
    host_cmd(host_pkg::HOST_BEGIN, 10'd0, 32'h0, 1'b1);
    host_cmd(host_pkg::HOST_END, 10'd0, 32'h0, 1'b0);
    check("epu_ready_o", 32'(epu_ready_o), 32'h1);
  endtask

  task test_no_ownership();
    logic [31:0] r;
    logic [9:0]  base;
    logic [31:0] act;
    r = next_rand();
    base = r[9:0];
    act = next_rand() | 32'h0101_0101;
    host_cmd(host_pkg::HOST_BEGIN, 10'd0, 32'h0, 1'b0);
    run_dot(base, 5, act, 32'h0, 1'b0, 1);
    host_cmd(host_pkg::HOST_END, 10'd0, 32'h0, 1'b0);
    // second start lands while busy and must leave no trace
    run_dot(base, 6, act, dot_model(base, 6, act), 1'b1, 12);
  endtask

  task test_reload();
    logic [31:0] r;
    logic [9:0]  base;
    logic [31:0] act;
    r = next_rand();
    base = r[9:0];
    act = next_rand();
    host_cmd(host_pkg::HOST_BEGIN, 10'd0, 32'h0, 1'b0);
    check("epu_ready_o", 32'(epu_ready_o), 32'h0);
    for (int k = 0; k < 8; k++) begin
      host_cmd(host_pkg::HOST_WRITE, base + k[9:0], next_rand(), 1'b0);
    end
    host_cmd(host_pkg::HOST_END, 10'd0, 32'h0, 1'b0);
    check("epu_ready_o", 32'(epu_ready_o), 32'h1);
    run_dot(base, 12, act, dot_model(base, 12, act), 1'b0, 1);
  endtask

  // watchdog
  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", WATCH_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    host_valid_i = 1'b0;
    host_req_i = '0;
    start_i = 1'b0;
    base_i = '0;
    len_i = '0;
    act_i = '0;
    rng_state = 32'haad59826;
    err_count = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_load_handover();
    test_random_runs();
    test_protocol_errors();
    test_no_ownership();
    test_reload();
    if (err_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "errors recorded");
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/epu_pkg.sv
hw/host_pkg.sv
hw/weight_sram.sv
hw/weight_wrapper.sv
hw/dot_engine.sv
hw/epu_top.sv
tests/tb_epu_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_epu_top \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
